/* common/video_pkg.sv */
// video format definitions shared by the splicer
// input, output and quadrant frame sizes
// output frame totals including blanking
// 32-bit and RGB565 pixel types and the pixel stream struct

package video_pkg;

	localparam int IN_H_ACTIVE  = 16;	// input pixels per line
	localparam int IN_V_ACTIVE  = 8;	// input lines per frame
	localparam int IN_FRAME_PIXELS = IN_H_ACTIVE * IN_V_ACTIVE;	// pixels accepted per frame

	localparam int OUT_H_ACTIVE = 16;	// active output pixels per line
	localparam int OUT_V_ACTIVE = 8;	// active output lines
	localparam int OUT_H_TOTAL  = 20;	// line length with blanking
	localparam int OUT_V_TOTAL  = 10;	// frame height with blanking

	localparam int QUAD_H = 8;	// quadrant width
	localparam int QUAD_V = 4;	// quadrant height

	// red 23..16, green 15..8, blue 7..0
	typedef logic [31:0] rgb888_t;

	// red 15..11, green 10..5, blue 4..0
	typedef logic [15:0] rgb565_t;

	typedef struct packed {
		logic    vs;	// one-cycle frame start
		logic    de;	// pixel valid
		rgb888_t data;
	} pixel_stream_t;

endpackage

/* common/store_pkg.sv */
// frame store definitions
// channel count, store depth and address type
// write request struct used by queues and the store port
// queue depth and grant wait bound

package store_pkg;

	localparam int NUM_CHANNELS   = 4;
	localparam int STORE_DEPTH    = 128;	// RGB565 words, whole output frame
	localparam int FIFO_DEPTH     = 8;	// entries per channel queue
	localparam int GRANT_WAIT_MAX = 4;	// worst wait of a queue head

	typedef logic [$clog2(STORE_DEPTH)-1:0]  store_addr_t;
	typedef logic [$clog2(NUM_CHANNELS)-1:0] chan_id_t;

	typedef struct packed {
		logic                 en;	// write valid, or queue not empty
		store_addr_t          addr;
		video_pkg::rgb565_t   data;
	} store_wr_t;

endpackage

/* channel_writer/write_fifo.sv */
// circular request queue for one channel
// head entry shown with en as not empty
// sticky overflow on a push into a full queue

`timescale 1ns/1ps

module write_fifo #(
	parameter int DEPTH = 8
) (
	input  logic                  O_axi_clk,
	input  logic                  arst_n,
	input  store_pkg::store_wr_t  push,
	input  logic                  pop,
	output store_pkg::store_wr_t  head,
	output logic                  overflow
);

	store_pkg::store_wr_t mem [DEPTH];

	logic [$clog2(DEPTH)-1:0] wr_ptr;
	logic [$clog2(DEPTH)-1:0] rd_ptr;
	logic [$clog2(DEPTH+1)-1:0] count;
	logic empty;
	logic full;
	logic do_push;
	logic do_pop;

	assign empty   = (count == '0);
	assign full    = (int'(count) == DEPTH);
	assign do_push = push.en && !full;	// entry lost when full
	assign do_pop  = pop && !empty;

	always_ff @(posedge O_axi_clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			overflow <= 1'b0;
		end else begin
			if (do_push)
				wr_ptr <= (int'(wr_ptr) == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (int'(rd_ptr) == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
			if (push.en && full)
				overflow <= 1'b1;	// held until reset
		end
	end

	always_ff @(posedge O_axi_clk) begin
		if (do_push)
			mem[wr_ptr] <= push;
	end

	assign head = '{en: !empty, addr: mem[rd_ptr].addr, data: mem[rd_ptr].data};

endmodule

/* channel_writer/channel_writer.sv */
// input side of one channel
// counts pixels of the incoming frame and drops the overflow
// keeps even column and even line pixels, converts to RGB565
// places them in the channel quadrant and queues the writes

`timescale 1ns/1ps

module channel_writer (
	input  logic                      O_axi_clk,
	input  logic                      arst_n,
	input  store_pkg::chan_id_t       chan,
	input  video_pkg::pixel_stream_t  pix,
	output store_pkg::store_wr_t      head,
	input  logic                      grant,
	output logic                      overflow
);

	logic [$clog2(video_pkg::IN_FRAME_PIXELS)-1:0] pix_idx;	// next pixel index
	logic [$clog2(video_pkg::IN_FRAME_PIXELS)-1:0] cur_idx;
	logic                                          frame_done;	// all pixels seen
	logic                                          cur_done;
	logic [$clog2(video_pkg::IN_H_ACTIVE)-1:0]     col;
	logic [$clog2(video_pkg::IN_V_ACTIVE)-1:0]     line;
	logic                                          keep;
	store_pkg::store_addr_t                        quad_addr;
	video_pkg::rgb565_t                            pix565;

	logic                    push_en;
	store_pkg::store_addr_t  push_addr;
	video_pkg::rgb565_t      push_data;
	store_pkg::store_wr_t    push;

	// vs restarts the count, same-cycle pixel is pixel 0
	assign cur_idx  = pix.vs ? '0 : pix_idx;
	assign cur_done = pix.vs ? 1'b0 : frame_done;
	assign {line, col} = cur_idx;

	assign keep = pix.de && !cur_done && !col[0] && !line[0];

	assign quad_addr = store_pkg::store_addr_t'(
		(int'(chan[1]) * video_pkg::QUAD_V + int'(line >> 1)) * video_pkg::OUT_H_ACTIVE +
		int'(chan[0]) * video_pkg::QUAD_H + int'(col >> 1));

	assign pix565 = {pix.data[23:19], pix.data[15:10], pix.data[7:3]};	// top bits of each field

	always_ff @(posedge O_axi_clk or negedge arst_n) begin
		if (!arst_n) begin
			pix_idx    <= '0;
			frame_done <= 1'b0;
		end else if (pix.de && !cur_done) begin
			pix_idx <= cur_idx + 1'b1;	// wraps to zero after the last pixel
			if (int'(cur_idx) == video_pkg::IN_FRAME_PIXELS - 1)
				frame_done <= 1'b1;
			else
				frame_done <= 1'b0;
		end else if (pix.vs) begin
			pix_idx    <= '0;
			frame_done <= 1'b0;
		end
	end

	always_ff @(posedge O_axi_clk or negedge arst_n) begin
		if (!arst_n)
			push_en <= 1'b0;
		else
			push_en <= keep;
	end

	always_ff @(posedge O_axi_clk) begin
		push_addr <= quad_addr;
		push_data <= pix565;
	end

	assign push = '{en: push_en, addr: push_addr, data: push_data};

	write_fifo #(
		.DEPTH (store_pkg::FIFO_DEPTH)
	) fifo_i (
		.O_axi_clk (O_axi_clk),
		.arst_n    (arst_n),
		.push      (push),
		.pop       (grant),
		.head      (head),
		.overflow  (overflow)
	);

endmodule

/* design/write_arbiter.sv */
// round-robin arbiter for the store write port
// searches from the queue after the last grant
// one-hot grant pops the queue in the same cycle
// granted entry is registered onto the store port

`timescale 1ns/1ps

module write_arbiter (
	input  logic                                O_axi_clk,
	input  logic                                arst_n,
	input  store_pkg::store_wr_t                heads [store_pkg::NUM_CHANNELS],
	output logic [store_pkg::NUM_CHANNELS-1:0]  grant,
	output store_pkg::store_wr_t                store_wr
);

	store_pkg::chan_id_t     last_q;	// last granted queue
	store_pkg::chan_id_t     sel;
	logic                    found;
	logic                    wr_en_q;
	store_pkg::store_addr_t  wr_addr_q;
	video_pkg::rgb565_t      wr_data_q;

	always_comb begin
		store_pkg::chan_id_t idx;
		grant = '0;
		sel   = last_q;
		found = 1'b0;
		for (int i = 1; i <= store_pkg::NUM_CHANNELS; i++) begin
			idx = last_q + store_pkg::chan_id_t'(i);	// wraps so the last one is checked last
			if (!found && heads[idx].en) begin
				found = 1'b1;
				sel   = idx;
			end
		end
		if (found)
			grant[sel] = 1'b1;
	end

	// starts at 3 so channel 0 goes first
	always_ff @(posedge O_axi_clk or negedge arst_n) begin
		if (!arst_n) begin
			last_q  <= store_pkg::chan_id_t'(store_pkg::NUM_CHANNELS - 1);
			wr_en_q <= 1'b0;
		end else begin
			wr_en_q <= found;
			if (found)
				last_q <= sel;
		end
	end

	always_ff @(posedge O_axi_clk) begin
		wr_addr_q <= heads[sel].addr;
		wr_data_q <= heads[sel].data;
	end

	assign store_wr = '{en: wr_en_q, addr: wr_addr_q, data: wr_data_q};

endmodule

/* design/frame_store.sv */
// frame store of RGB565 words
// synchronous write, registered read
// read of the address being written returns the old word

`timescale 1ns/1ps

module frame_store (
	input  logic                    O_axi_clk,
	input  store_pkg::store_wr_t    wr,
	input  store_pkg::store_addr_t  rd_addr,
	output video_pkg::rgb565_t      rd_data
);

	video_pkg::rgb565_t mem [store_pkg::STORE_DEPTH];

	always_ff @(posedge O_axi_clk) begin
		if (wr.en)
			mem[wr.addr] <= wr.data;
	end

	always_ff @(posedge O_axi_clk) begin
		rd_data <= mem[rd_addr];	// one-cycle latency
	end

endmodule

/* design/scan_out.sv */
// output frame timing generator
// free-running h and v counters with a small blanking interval
// raster-order store read, vs and de aligned to the read data
// RGB565 expanded back to the 32-bit pixel word

`timescale 1ns/1ps

module scan_out (
	input  logic                      O_axi_clk,
	input  logic                      arst_n,
	output store_pkg::store_addr_t    rd_addr,
	input  video_pkg::rgb565_t        rd_data,
	output video_pkg::pixel_stream_t  out_pix
);

	logic [$clog2(video_pkg::OUT_H_TOTAL)-1:0] h_cnt;
	logic [$clog2(video_pkg::OUT_V_TOTAL)-1:0] v_cnt;
	logic active;
	logic sof;	// first active pixel of the frame
	logic de_q;
	logic vs_q;

	always_ff @(posedge O_axi_clk or negedge arst_n) begin
		if (!arst_n) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (int'(h_cnt) == video_pkg::OUT_H_TOTAL - 1) begin
			h_cnt <= '0;
			if (int'(v_cnt) == video_pkg::OUT_V_TOTAL - 1)
				v_cnt <= '0;
			else
				v_cnt <= v_cnt + 1'b1;
		end else begin
			h_cnt <= h_cnt + 1'b1;
		end
	end

	assign active = (int'(h_cnt) < video_pkg::OUT_H_ACTIVE) &&
		(int'(v_cnt) < video_pkg::OUT_V_ACTIVE);
	assign sof = (h_cnt == '0) && (v_cnt == '0);

	assign rd_addr = store_pkg::store_addr_t'(int'(v_cnt) * video_pkg::OUT_H_ACTIVE +
		int'(h_cnt));	// raster order, only meaningful while active

	// one cycle to meet the store read latency
	always_ff @(posedge O_axi_clk or negedge arst_n) begin
		if (!arst_n) begin
			de_q <= 1'b0;
			vs_q <= 1'b0;
		end else begin
			de_q <= active;
			vs_q <= sof;
		end
	end

	assign out_pix.vs   = vs_q;
	assign out_pix.de   = de_q;
	assign out_pix.data = {8'h00,
		rd_data[15:11], 3'b000,	// red
		rd_data[10:5], 2'b00,	// green
		rd_data[4:0], 3'b000};	// blue

endmodule

/* design/video_splicer.sv */
// four-channel video splicer top level
// four channel writers share one store write port via the arbiter
// scan-out reads the composed frame from the store

`timescale 1ns/1ps

module video_splicer (
	input  logic                                O_axi_clk,
	input  logic                                arst_n,
	input  video_pkg::pixel_stream_t            in_pix [store_pkg::NUM_CHANNELS],
	output video_pkg::pixel_stream_t            out_pix,
	output logic [store_pkg::NUM_CHANNELS-1:0]  overflow
);

	store_pkg::store_wr_t                heads [store_pkg::NUM_CHANNELS];
	logic [store_pkg::NUM_CHANNELS-1:0]  grant;
	store_pkg::store_wr_t                store_wr;
	store_pkg::store_addr_t              rd_addr;
	video_pkg::rgb565_t                  rd_data;

	for (genvar k = 0; k < store_pkg::NUM_CHANNELS; k++) begin : g_chan
		channel_writer writer_i (
			.O_axi_clk (O_axi_clk),
			.arst_n    (arst_n),
			.chan      (store_pkg::chan_id_t'(k)),	// quadrant select
			.pix       (in_pix[k]),
			.head      (heads[k]),
			.grant     (grant[k]),
			.overflow  (overflow[k])
		);
	end

	write_arbiter arbiter_i (
		.O_axi_clk (O_axi_clk),
		.arst_n    (arst_n),
		.heads     (heads),
		.grant     (grant),
		.store_wr  (store_wr)
	);

	frame_store store_i (
		.O_axi_clk (O_axi_clk),
		.wr        (store_wr),
		.rd_addr   (rd_addr),
		.rd_data   (rd_data)
	);

	scan_out scan_i (
		.O_axi_clk (O_axi_clk),
		.arst_n    (arst_n),
		.rd_addr   (rd_addr),
		.rd_data   (rd_data),
		.out_pix   (out_pix)
	);

endmodule

/* test/splicer_properties.sv */
// arbiter checks bound into write_arbiter
// grant one-hot or zero, grant only to a non-empty head
// bounded wait of every non-empty head
// count of failed assertions

`timescale 1ns/1ps

module splicer_properties (
	input logic                                O_axi_clk,
	input logic                                arst_n,
	input store_pkg::store_wr_t                heads [store_pkg::NUM_CHANNELS],
	input logic [store_pkg::NUM_CHANNELS-1:0]  grant
);

	logic [store_pkg::NUM_CHANNELS-1:0] req;
	int wait_cnt [store_pkg::NUM_CHANNELS];	// cycles a head has waited so far
	int assert_fails = 0;

	always_comb begin
		for (int k = 0; k < store_pkg::NUM_CHANNELS; k++)
			req[k] = heads[k].en;
	end

	always_ff @(posedge O_axi_clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int k = 0; k < store_pkg::NUM_CHANNELS; k++)
				wait_cnt[k] <= 0;
		end else begin
			for (int k = 0; k < store_pkg::NUM_CHANNELS; k++)
				wait_cnt[k] <= (req[k] && !grant[k]) ? wait_cnt[k] + 1 : 0;
		end
	end

	grant_onehot: assert property (@(posedge O_axi_clk) disable iff (!arst_n)
		$onehot0(grant))
		else begin
			$error("arbiter grant has more than one bit set");
			assert_fails++;
		end

	grant_to_request: assert property (@(posedge O_axi_clk) disable iff (!arst_n)
		(grant & ~req) == '0)
		else begin
			$error("arbiter granted an empty queue");
			assert_fails++;
		end

	for (genvar k = 0; k < store_pkg::NUM_CHANNELS; k++) begin : g_wait
		wait_bound: assert property (@(posedge O_axi_clk) disable iff (!arst_n)
			wait_cnt[k] < store_pkg::GRANT_WAIT_MAX)
			else begin
				$error("queue head %0d waited too long for a grant", k);
				assert_fails++;
			end
	end

endmodule

bind write_arbiter splicer_properties props_i (
	.O_axi_clk (O_axi_clk),
	.arst_n    (arst_n),
	.heads     (heads),
	.grant     (grant)
);

/* test/splicer_checker.sv */
// reference model of the composed output frame
// tracks input pixels per channel, decimates and places them
// compares one whole output frame on request

`timescale 1ns/1ps

module splicer_checker (
	input  logic                      O_axi_clk,
	input  logic                      arst_n,
	input  video_pkg::pixel_stream_t  in_pix [store_pkg::NUM_CHANNELS],
	input  video_pkg::pixel_stream_t  out_pix,
	input  logic                      check_req,
	output int                        checks_done,
	output int                        check_errors
);

	localparam int FRAME_WORDS   = video_pkg::OUT_H_ACTIVE * video_pkg::OUT_V_ACTIVE;
	localparam int FRAME_TIMEOUT = 2 * video_pkg::OUT_H_TOTAL * video_pkg::OUT_V_TOTAL;

	video_pkg::rgb888_t expected [FRAME_WORDS];
	int in_count [store_pkg::NUM_CHANNELS];	// pixels seen in the current input frame
	int model_idx;

	// 565 reduction then zero-filled expansion
	function automatic video_pkg::rgb888_t reduce_expand(input video_pkg::rgb888_t px);
		return {8'h00, px[23:19], 3'b000, px[15:10], 2'b00, px[7:3], 3'b000};
	endfunction

	function automatic int place_addr(input int k, input int idx);
		int col;
		int line;
		col  = idx % video_pkg::IN_H_ACTIVE;
		line = idx / video_pkg::IN_H_ACTIVE;
		return ((k / 2) * video_pkg::QUAD_V + line / 2) * video_pkg::OUT_H_ACTIVE +
			(k % 2) * video_pkg::QUAD_H + col / 2;
	endfunction

	always @(posedge O_axi_clk) begin
		for (int k = 0; k < store_pkg::NUM_CHANNELS; k++) begin
			if (!arst_n) begin
				in_count[k] = 0;
			end else begin
				model_idx = in_pix[k].vs ? 0 : in_count[k];	// vs pixel is pixel 0
				if (in_pix[k].de && model_idx < video_pkg::IN_FRAME_PIXELS) begin
					if (model_idx % 2 == 0 && (model_idx / video_pkg::IN_H_ACTIVE) % 2 == 0)
						expected[place_addr(k, model_idx)] = reduce_expand(in_pix[k].data);
					in_count[k] = model_idx + 1;
				end else if (in_pix[k].vs) begin
					in_count[k] = 0;
				end
			end
		end
	end

	task automatic compare_frame();
		int errs;
		int waited;
		int pix;
		errs   = 0;
		waited = 0;
		while (!out_pix.vs && waited < FRAME_TIMEOUT) begin
			@(posedge O_axi_clk);
			waited++;
		end
		if (!out_pix.vs) begin
			$display("no output frame start seen within %0d cycles", FRAME_TIMEOUT);
			errs++;
		end else begin
			pix    = 0;
			waited = 0;
			while (pix < FRAME_WORDS && waited < FRAME_TIMEOUT) begin
				if (out_pix.de) begin
					if (out_pix.data !== expected[pix]) begin
						$display("[FAIL] t=%0t out_pix.data[%0d] got %08h expected %08h",
							$time, pix, out_pix.data, expected[pix]);
						errs++;
					end
					pix++;
				end
				if (pix < FRAME_WORDS) begin
					@(posedge O_axi_clk);
					waited++;
				end
			end
			if (pix < FRAME_WORDS) begin
				$display("output frame ended early, only %0d of %0d pixels seen", pix, FRAME_WORDS);
				errs++;
			end
		end
		check_errors <= errs;
		checks_done  <= checks_done + 1;
	endtask

	initial begin
		checks_done  <= 0;
		check_errors <= 0;
		forever begin
			@(posedge O_axi_clk);
			if (check_req)
				compare_frame();
		end
	end

endmodule

/* test/tb_video_splicer.sv */
// testbench top for the video splicer
// clock, reset, LFSR pixel stimulus and test sequence
// checker and bound arbiter properties watch the DUT

`timescale 1ns/1ps

module tb_video_splicer;

	localparam int NCH        = store_pkg::NUM_CHANNELS;
	localparam int SEND_MAX   = 4000;	// cycles to deliver one set of frames
	localparam int FRAME_WAIT = 250;	// a little over one output frame
	localparam int CHECK_WAIT = 600;

	logic O_axi_clk = 1'b0;
	logic arst_n;
	video_pkg::pixel_stream_t in_pix [NCH];
	video_pkg::pixel_stream_t out_pix;
	logic [NCH-1:0] overflow;
	logic check_req;
	int checks_done;
	int check_errors;
	logic [15:0] lfsr_state = 16'd69;
	logic overflow_seen = 1'b0;
	int errors = 0;
	int assert_seen = 0;	// arbiter assertion failures already counted
	int tests_run = 0;
	int tests_failed = 0;

	always #10 O_axi_clk = ~O_axi_clk;

	video_splicer dut_i (
		.O_axi_clk (O_axi_clk),
		.arst_n    (arst_n),
		.in_pix    (in_pix),
		.out_pix   (out_pix),
		.overflow  (overflow)
	);

	splicer_checker checker_i (
		.O_axi_clk    (O_axi_clk),
		.arst_n       (arst_n),
		.in_pix       (in_pix),
		.out_pix      (out_pix),
		.check_req    (check_req),
		.checks_done  (checks_done),
		.check_errors (check_errors)
	);

	always @(posedge O_axi_clk) begin
		if (overflow != '0)
			overflow_seen <= 1'b1;
	end

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_state[0]};
			lfsr_state = lfsr_step(lfsr_state);
		end
		return v;
	endfunction

	task automatic expect_value(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("[FAIL] t=%0t %s got %0d expected %0d", $time, name, got, exp);
			errors++;
		end
	endtask

	// vs on the first cycle, then count pixels per masked channel with random gaps
	task automatic send_frames(input logic [NCH-1:0] mask, input int count);
		int sent [NCH];
		logic last_de [NCH];
		int cycles;
		logic busy;
		logic de;
		cycles = 0;
		busy   = 1'b1;
		for (int k = 0; k < NCH; k++) begin
			sent[k]    = mask[k] ? 0 : count;
			last_de[k] = 1'b0;
		end
		while (busy && cycles < SEND_MAX) begin
			busy = 1'b0;
			for (int k = 0; k < NCH; k++) begin
				de = (sent[k] < count) && !last_de[k] && (take_bits(1) != 0);
				in_pix[k] <= '{vs: mask[k] && (cycles == 0), de: de,
					data: de ? take_bits(32) : 32'h0};
				if (de)
					sent[k]++;
				last_de[k] = de;
				if (sent[k] < count)
					busy = 1'b1;
			end
			@(posedge O_axi_clk);
			cycles++;
		end
		for (int k = 0; k < NCH; k++)
			in_pix[k] <= '0;
		@(posedge O_axi_clk);	// idle cycle between calls
		if (busy) begin
			$display("input frames not delivered within %0d cycles", SEND_MAX);
			errors++;
		end
	endtask

	// counts de from the current sample up to the next vs
	task automatic wait_out_vs(output int cycles, output int des);
		cycles = 0;
		des    = 0;
		do begin
			if (out_pix.de)
				des++;
			@(posedge O_axi_clk);
			cycles++;
		end while (!out_pix.vs && cycles < FRAME_WAIT);
		if (!out_pix.vs) begin
			$display("no output vs within %0d cycles", FRAME_WAIT);
			errors++;
		end
	endtask

	task automatic request_compare();
		int start;
		int waited;
		start     = checks_done;
		waited    = 0;
		check_req <= 1'b1;
		@(posedge O_axi_clk);
		check_req <= 1'b0;
		while (checks_done == start && waited < CHECK_WAIT) begin
			@(posedge O_axi_clk);
			waited++;
		end
		if (checks_done == start) begin
			$display("frame comparison did not finish within %0d cycles", CHECK_WAIT);
			errors++;
		end else begin
			errors += check_errors;
		end
	endtask

	task automatic finish_test(input string name, input int errs_before);
		int fails;
		fails       = dut_i.arbiter_i.props_i.assert_fails;
		errors      += fails - assert_seen;
		assert_seen = fails;
		tests_run++;
		if (errors > errs_before) begin
			tests_failed++;
			$display("test %s: FAILED with %0d errors", name, errors - errs_before);
		end else begin
			$display("test %s: ok", name);
		end
	endtask

	initial begin
		int cycles;
		int des;
		int errs_before;
		arst_n    <= 1'b0;
		check_req <= 1'b0;
		for (int k = 0; k < NCH; k++)
			in_pix[k] <= '0;
		repeat (8) @(posedge O_axi_clk);
		errs_before = errors;
		expect_value("out_pix.de", int'(out_pix.de), 0);
		expect_value("out_pix.vs", int'(out_pix.vs), 0);
		expect_value("overflow", int'(overflow), 0);
		expect_value("grant", int'(dut_i.grant), 0);
		expect_value("store_wr.en", int'(dut_i.store_wr.en), 0);
		arst_n <= 1'b1;
		wait_out_vs(cycles, des);
		expect_value("de before first vs", des, 0);
		if (cycles > video_pkg::OUT_H_TOTAL * video_pkg::OUT_V_TOTAL) begin
			$display("first output vs came only after %0d cycles", cycles);
			errors++;
		end
		finish_test("reset", errs_before);

		errs_before = errors;
		for (int f = 0; f < 3; f++) begin
			wait_out_vs(cycles, des);
			expect_value("frame period", cycles, video_pkg::OUT_H_TOTAL * video_pkg::OUT_V_TOTAL);
			expect_value("de per frame", des, video_pkg::OUT_H_ACTIVE * video_pkg::OUT_V_ACTIVE);
			expect_value("out_pix.de at vs", int'(out_pix.de), 1);
		end
		finish_test("frame timing", errs_before);

		errs_before = errors;
		send_frames('1, video_pkg::IN_FRAME_PIXELS);
		repeat (40) @(posedge O_axi_clk);
		request_compare();
		finish_test("composition", errs_before);

		errs_before = errors;
		send_frames('1, video_pkg::IN_FRAME_PIXELS + 20);	// extras past the frame
		send_frames(4'b0100, 50);	// channel 2 cut short by a new vs
		send_frames(4'b0100, video_pkg::IN_FRAME_PIXELS);
		repeat (40) @(posedge O_axi_clk);
		request_compare();
		finish_test("overwrite and overcount", errs_before);

		errs_before = errors;
		expect_value("overflow sticky", int'(overflow_seen), 0);
		expect_value("overflow", int'(overflow), 0);
		finish_test("no overflow", errs_before);

		$display("tests run %0d, passed %0d, failed %0d",
			tests_run, tests_run - tests_failed, tests_failed);
		if (tests_failed == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

/* compile.f */
common/video_pkg.sv
common/store_pkg.sv
channel_writer/write_fifo.sv
channel_writer/channel_writer.sv
design/write_arbiter.sv
design/frame_store.sv
design/scan_out.sv
design/video_splicer.sv
test/splicer_properties.sv
test/splicer_checker.sv
test/tb_video_splicer.sv

/* Makefile */
# Verilator build and run of the video splicer testbench

VERILATOR ?= verilator
TOP       ?= tb_video_splicer
BUILD_DIR ?= obj_dir
FILELIST  ?= compile.f
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Testbench passed

SOURCES := $(filter-out +incdir+%,$(shell cat $(FILELIST)))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
